// File: hdl/tcu_fedp_int.sv
// One integer fused dot-product lane of the tile.
// Multiplies packed int8/uint8/int4/uint4 sub-words of A and B, reduces the
// per-word products through a registered adder tree and adds C.
// Latency is TCU_FEDP_LAT enabled cycles, one new operand per cycle.
`timescale 1ns/100ps
`include "tcu_settings.svh"

module tcu_fedp_int (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  tcu_pkg::tcu_lane_op_t op,
    output tcu_pkg::tcu_word_t    d
);

    localparam int LEVELS = $clog2(`TCU_N);
    // widest per-word sum is 18 bits, plus a guard bit for unsigned formats
    localparam int PSELW  = 19;
    localparam int REDW   = PSELW + LEVELS;

    // half-word partial sums for all four formats, computed side by side
    typedef struct packed {
        logic signed [16:0] s8_lo;
        logic signed [16:0] s8_hi;
        logic        [16:0] u8_lo;
        logic        [16:0] u8_hi;
        logic signed [9:0]  s4_lo;
        logic signed [9:0]  s4_hi;
        logic        [9:0]  u4_lo;
        logic        [9:0]  u4_hi;
    } part_t;

    typedef logic signed [PSELW-1:0] psel_t;
    typedef logic signed [REDW-1:0]  red_t;

    function automatic logic signed [16:0] dot_s8(input logic [15:0] a, input logic [15:0] b);
        logic signed [16:0] acc;
        acc = '0;
        for (int k = 0; k < 2; k++) begin
            acc += $signed(a[8*k +: 8]) * $signed(b[8*k +: 8]);
        end
        return acc;
    endfunction

    function automatic logic [16:0] dot_u8(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] acc;
        acc = '0;
        for (int k = 0; k < 2; k++) begin
            acc += a[8*k +: 8] * b[8*k +: 8];
        end
        return acc;
    endfunction

    function automatic logic signed [9:0] dot_s4(input logic [15:0] a, input logic [15:0] b);
        logic signed [9:0] acc;
        acc = '0;
        for (int k = 0; k < 4; k++) begin
            acc += $signed(a[4*k +: 4]) * $signed(b[4*k +: 4]);
        end
        return acc;
    endfunction

    function automatic logic [9:0] dot_u4(input logic [15:0] a, input logic [15:0] b);
        logic [9:0] acc;
        acc = '0;
        for (int k = 0; k < 4; k++) begin
            acc += a[4*k +: 4] * b[4*k +: 4];
        end
        return acc;
    endfunction

    tcu_pkg::tcu_fmt_e  fmt_dly;
    tcu_pkg::tcu_word_t c_dly;
    tcu_pkg::tcu_word_t acc_sum;
    psel_t              mult [`TCU_N];
    red_t               red [LEVELS+1][`TCU_N];

    // format lines up with the select stage
    tcu_pipe_reg #(.payload_t(tcu_pkg::tcu_fmt_e), .DEPTH(`TCU_MUL_LAT - 1)) fmt_dly_i (
        .clk(clk), .rst_n(rst_n), .enable(enable), .data_in(op.fmt), .data_out(fmt_dly)
    );

    for (genvar i = 0; i < `TCU_N; i++) begin : g_word
        part_t              part_d;
        part_t              part_q;
        logic signed [17:0] sum_s8;
        logic        [17:0] sum_u8;
        logic signed [10:0] sum_s4;
        logic        [10:0] sum_u4;
        psel_t              mult_sel;

        assign part_d.s8_lo = dot_s8(op.a_row[i][15:0], op.b_col[i][15:0]);
        assign part_d.s8_hi = dot_s8(op.a_row[i][31:16], op.b_col[i][31:16]);
        assign part_d.u8_lo = dot_u8(op.a_row[i][15:0], op.b_col[i][15:0]);
        assign part_d.u8_hi = dot_u8(op.a_row[i][31:16], op.b_col[i][31:16]);
        assign part_d.s4_lo = dot_s4(op.a_row[i][15:0], op.b_col[i][15:0]);
        assign part_d.s4_hi = dot_s4(op.a_row[i][31:16], op.b_col[i][31:16]);
        assign part_d.u4_lo = dot_u4(op.a_row[i][15:0], op.b_col[i][15:0]);
        assign part_d.u4_hi = dot_u4(op.a_row[i][31:16], op.b_col[i][31:16]);

        tcu_pipe_reg #(.payload_t(part_t), .DEPTH(1)) part_i (
            .clk(clk), .rst_n(rst_n), .enable(enable), .data_in(part_d), .data_out(part_q)
        );

        assign sum_s8 = $signed(part_q.s8_lo) + $signed(part_q.s8_hi);
        assign sum_u8 = part_q.u8_lo + part_q.u8_hi;
        assign sum_s4 = $signed(part_q.s4_lo) + $signed(part_q.s4_hi);
        assign sum_u4 = part_q.u4_lo + part_q.u4_hi;

        // sign or zero extension follows the format
        always_comb begin
            case (fmt_dly)
                tcu_pkg::TCU_FMT_I8: mult_sel = psel_t'(sum_s8);
                tcu_pkg::TCU_FMT_U8: mult_sel = psel_t'(sum_u8);
                tcu_pkg::TCU_FMT_I4: mult_sel = psel_t'(sum_s4);
                tcu_pkg::TCU_FMT_U4: mult_sel = psel_t'(sum_u4);
                default:             mult_sel = '0;
            endcase
        end

        tcu_pipe_reg #(.payload_t(psel_t), .DEPTH(1)) sel_i (
            .clk(clk), .rst_n(rst_n), .enable(enable), .data_in(mult_sel), .data_out(mult[i])
        );

        assign red[0][i] = red_t'(mult[i]);
    end

    // pairwise adder tree, one register per level
    for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_lvl
        for (genvar i = 0; i < (`TCU_N >> (lvl + 1)); i++) begin : g_add
            red_t pair_sum;
            assign pair_sum = red[lvl][2*i] + red[lvl][2*i+1];
            tcu_pipe_reg #(.payload_t(red_t), .DEPTH(1)) add_i (
                .clk(clk), .rst_n(rst_n), .enable(enable),
                .data_in(pair_sum), .data_out(red[lvl+1][i])
            );
        end
    end

    tcu_pipe_reg #(.payload_t(tcu_pkg::tcu_word_t), .DEPTH(`TCU_MUL_LAT + LEVELS)) c_dly_i (
        .clk(clk), .rst_n(rst_n), .enable(enable), .data_in(op.c_val), .data_out(c_dly)
    );

    // wraps to 32 bits like the register result
    assign acc_sum = tcu_pkg::tcu_word_t'(red[LEVELS][0]) + c_dly;

    tcu_pipe_reg #(.payload_t(tcu_pkg::tcu_word_t), .DEPTH(1)) acc_i (
        .clk(clk), .rst_n(rst_n), .enable(enable), .data_in(acc_sum), .data_out(d)
    );

endmodule

// File: hdl/tcu_int_tile.sv
// Top level of the integer tensor-core tile.
// A request of one A row, TCU_LANES B columns and C words enters on req_valid;
// the response appears on rsp_valid seven enabled cycles later.
// Holding enable low freezes the whole pipeline.
`timescale 1ns/100ps
`include "tcu_settings.svh"

module tcu_int_tile (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              enable,
    input  logic              req_valid,
    input  tcu_pkg::tcu_req_t req,
    output logic              rsp_valid,
    output tcu_pkg::tcu_rsp_t rsp,
    output logic              fmt_error
);

    tcu_pkg::tcu_lane_op_t [`TCU_LANES-1:0] lane_op;
    tcu_pkg::tcu_word_t    [`TCU_LANES-1:0] lane_d;
    logic                                   op_valid;

    tcu_operand_dispatch dispatch_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .req_valid (req_valid),
        .req       (req),
        .lane_op   (lane_op),
        .op_valid  (op_valid),
        .fmt_error (fmt_error)
    );

    // identical lanes, one per B column
    for (genvar l = 0; l < `TCU_LANES; l++) begin : g_lane
        tcu_fedp_int lane_i (
            .clk    (clk),
            .rst_n  (rst_n),
            .enable (enable),
            .op     (lane_op[l]),
            .d      (lane_d[l])
        );
    end

    tcu_result_collect collect_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .op_valid  (op_valid),
        .lane_d    (lane_d),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

// File: hdl/tcu_operand_dispatch.sv
// Request front end of the tile.
// Rejects unsupported formats with a one-cycle fmt_error pulse, registers
// accepted requests and fans them out as one operand bundle per lane.
`timescale 1ns/100ps
`include "tcu_settings.svh"

module tcu_operand_dispatch (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      enable,
    input  logic                                      req_valid,
    input  tcu_pkg::tcu_req_t                         req,
    output tcu_pkg::tcu_lane_op_t [`TCU_LANES-1:0]    lane_op,
    output logic                                      op_valid,
    output logic                                      fmt_error
);

    function automatic logic fmt_supported(input tcu_pkg::tcu_fmt_e fmt);
        case (fmt)
            tcu_pkg::TCU_FMT_I8,
            tcu_pkg::TCU_FMT_U8,
            tcu_pkg::TCU_FMT_I4,
            tcu_pkg::TCU_FMT_U4: return 1'b1;
            default:             return 1'b0;
        endcase
    endfunction

    logic              fmt_ok;
    tcu_pkg::tcu_req_t req_q;

    assign fmt_ok = fmt_supported(req.fmt);

    // strobes hold their level while enable is low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_valid  <= 1'b0;
            fmt_error <= 1'b0;
        end else if (enable) begin
            op_valid  <= req_valid && fmt_ok;
            fmt_error <= req_valid && !fmt_ok;
        end
    end

    // dropped requests leave the payload untouched
    always_ff @(posedge clk) begin
        if (enable && req_valid && fmt_ok) begin
            req_q <= req;
        end
    end

    // every lane sees the same A row and its own B column and C
    always_comb begin
        for (int l = 0; l < `TCU_LANES; l++) begin
            lane_op[l].fmt   = req_q.fmt;
            lane_op[l].a_row = req_q.a_row;
            lane_op[l].b_col = req_q.b_cols[l];
            lane_op[l].c_val = req_q.c_vals[l];
        end
    end

endmodule

// File: hdl/tcu_pipe_reg.sv
// Enable-gated register chain with a configurable depth and payload type.
// Set RESET_EN for control bits; data chains leave it clear and carry no reset.
`timescale 1ns/100ps

module tcu_pipe_reg #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1,
    parameter bit  RESET_EN  = 1'b0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     enable,
    input  payload_t data_in,
    output payload_t data_out
);

    payload_t stages [DEPTH];

    always_ff @(posedge clk) begin
        if (RESET_EN && !rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= payload_t'('0);
            end
        end else if (enable) begin
            stages[0] <= data_in;
            // shift toward the output
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign data_out = stages[DEPTH-1];

endmodule

// File: hdl/tcu_pkg.sv
// Shared types for the integer tensor-core tile.
// Modules reach into this package with scoped names.

`include "tcu_settings.svh"

package tcu_pkg;

    // data format of a request, all other codes are rejected
    typedef enum logic [2:0] {
        TCU_FMT_I8 = 3'd1,
        TCU_FMT_U8 = 3'd2,
        TCU_FMT_I4 = 3'd3,
        TCU_FMT_U4 = 3'd4
    } tcu_fmt_e;

    typedef logic [`TCU_XLEN-1:0] tcu_word_t;

    // everything one lane needs for a single dot product
    typedef struct packed {
        tcu_fmt_e                    fmt;
        tcu_word_t [`TCU_N-1:0]      a_row;
        tcu_word_t [`TCU_N-1:0]      b_col;
        tcu_word_t                   c_val;
    } tcu_lane_op_t;

    // one tile request: A row shared by all lanes, one B column and C per lane
    typedef struct packed {
        tcu_fmt_e                                 fmt;
        tcu_word_t [`TCU_N-1:0]                   a_row;
        tcu_word_t [`TCU_LANES-1:0][`TCU_N-1:0]   b_cols;
        tcu_word_t [`TCU_LANES-1:0]               c_vals;
    } tcu_req_t;

    // one result word per lane
    typedef struct packed {
        tcu_word_t [`TCU_LANES-1:0] d;
    } tcu_rsp_t;

endpackage

// File: hdl/tcu_result_collect.sv
// Response back end of the tile.
// Carries op_valid down a valid chain as deep as a lane, so each set bit
// marks a pipeline slot with live work, then registers the lane results
// into one response with a one-cycle rsp_valid strobe.
`timescale 1ns/100ps
`include "tcu_settings.svh"

module tcu_result_collect (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  enable,
    input  logic                                  op_valid,
    input  tcu_pkg::tcu_word_t [`TCU_LANES-1:0]   lane_d,
    output logic                                  rsp_valid,
    output tcu_pkg::tcu_rsp_t                     rsp
);

    logic valid_dly;

    // slot tracking, cleared by reset so no stale work survives
    tcu_pipe_reg #(
        .payload_t (logic),
        .DEPTH     (`TCU_FEDP_LAT),
        .RESET_EN  (1'b1)
    ) valid_chain_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .data_in  (op_valid),
        .data_out (valid_dly)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (enable) begin
            rsp_valid <= valid_dly;
        end
    end

    // capture lane words only for a live slot
    always_ff @(posedge clk) begin
        if (enable && valid_dly) begin
            for (int l = 0; l < `TCU_LANES; l++) begin
                rsp.d[l] <= lane_d[l];
            end
        end
    end

endmodule

// File: hdl/tcu_settings.svh
// Sizing and latency macros for the integer tensor-core tile.
// Include this file wherever a width, the lane count or a pipeline depth is needed.
// TCU_N must stay a power of two so that the lane adder tree is balanced.
`ifndef TCU_SETTINGS_SVH
`define TCU_SETTINGS_SVH

// register word width, fixed at 32 bits
`define TCU_XLEN 32

// packed words per dot product
`define TCU_N 4

// dot-product lanes per tile
`define TCU_LANES 4

// product stage then format select stage
`define TCU_MUL_LAT 2

// lane latency: multiply, one cycle per tree level, final accumulate
`define TCU_FEDP_LAT (`TCU_MUL_LAT + $clog2(`TCU_N) + 1)

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the tile testbench with Verilator, runs it and checks for the pass message.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tcu_int_tile_tb -f vlog.f -o tcu_int_tile_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tcu_int_tile_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST OK" <<< "$sim_out"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: tb/tcu_int_tile_assert.sv
// Concurrent checks on the top-level ports of the tile.
// Bound into every tcu_int_tile instance; a failing property raises $error.
`timescale 1ns/100ps

module tcu_int_tile_assert (
    input logic clk,
    input logic rst_n,
    input logic enable,
    input logic rsp_valid,
    input logic fmt_error
);

    // strobes are cleared by every reset edge
    a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !rsp_valid && !fmt_error)
        else $error("rsp_valid or fmt_error high after a reset edge");

    // a rejected request leaves its response slot empty six enabled cycles later
    a_bad_slot_empty: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && $past(enable, 1) && $past(enable, 2) && $past(enable, 3)
        && $past(enable, 4) && $past(enable, 5) && $past(enable, 6)
        |-> !$past(fmt_error, 6))
        else $error("response produced for a slot that raised fmt_error");

    // strobes only move on enabled edges
    a_hold_when_stalled: assert property (@(posedge clk)
        $past(rst_n) && !$past(enable) |-> $stable(rsp_valid) && $stable(fmt_error))
        else $error("rsp_valid or fmt_error changed while enable was low");

endmodule

bind tcu_int_tile tcu_int_tile_assert tcu_int_tile_assert_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .enable    (enable),
    .rsp_valid (rsp_valid),
    .fmt_error (fmt_error)
);

// File: tb/tcu_int_tile_tb.sv
// Directed testbench for the integer tensor-core tile.
// Predicts every lane with a reference model of the dot-product rule and checks
// responses, latency in enabled cycles, fmt_error pulses and holding while enable is low.
`timescale 1ns/100ps
`include "tcu_settings.svh"

module tcu_int_tile_tb;

    localparam int CLK_PERIOD = 8;
    localparam int RSP_LAT    = `TCU_FEDP_LAT + 2;
    localparam int NUM_REQS   = 40;
    localparam int QUIET      = 12;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              enable;
    logic              req_valid;
    tcu_pkg::tcu_req_t req;
    logic              rsp_valid;
    tcu_pkg::tcu_rsp_t rsp;
    logic              fmt_error;

    integer            seed;
    tcu_pkg::tcu_rsp_t exp_q[$];
    int                acc_q[$];
    int                en_edges   = 0;
    int                rsp_count  = 0;
    int                sent_ok    = 0;
    int                ferr_count = 0;
    int                exp_ferr   = 0;
    logic              edge_en;
    logic              edge_rst;
    logic              prev_valid;
    logic              prev_ferr;
    tcu_pkg::tcu_rsp_t prev_rsp;

    tcu_int_tile tcu_int_tile_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .fmt_error (fmt_error)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run aborted on first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    function automatic bit supported_fmt(input logic [2:0] f);
        return (f >= 3'd1) && (f <= 3'd4);
    endfunction

    // C plus the sum of all sub-field products, wrapped to 32 bits
    function automatic tcu_pkg::tcu_word_t lane_ref(input tcu_pkg::tcu_req_t r, input int l);
        int                 width;
        bit                 sgn;
        int                 av;
        int                 bv;
        tcu_pkg::tcu_word_t acc;
        width = (r.fmt == tcu_pkg::TCU_FMT_I8 || r.fmt == tcu_pkg::TCU_FMT_U8) ? 8 : 4;
        sgn   = (r.fmt == tcu_pkg::TCU_FMT_I8 || r.fmt == tcu_pkg::TCU_FMT_I4);
        acc   = r.c_vals[l];
        for (int w = 0; w < `TCU_N; w++) begin
            for (int f = 0; f < 32 / width; f++) begin
                av = (r.a_row[w] >> (f * width)) & ((1 << width) - 1);
                bv = (r.b_cols[l][w] >> (f * width)) & ((1 << width) - 1);
                if (sgn && av >= (1 << (width - 1))) av -= (1 << width);
                if (sgn && bv >= (1 << (width - 1))) bv -= (1 << width);
                acc += av * bv;
            end
        end
        return acc;
    endfunction

    function automatic tcu_pkg::tcu_rsp_t model_rsp(input tcu_pkg::tcu_req_t r);
        tcu_pkg::tcu_rsp_t m;
        for (int l = 0; l < `TCU_LANES; l++) m.d[l] = lane_ref(r, l);
        return m;
    endfunction

    task automatic rand_req(input logic [2:0] fmt, output tcu_pkg::tcu_req_t r);
        r.fmt = tcu_pkg::tcu_fmt_e'(fmt);
        for (int w = 0; w < `TCU_N; w++) r.a_row[w] = $random(seed);
        for (int l = 0; l < `TCU_LANES; l++) begin
            for (int w = 0; w < `TCU_N; w++) r.b_cols[l][w] = $random(seed);
            r.c_vals[l] = $random(seed);
        end
    endtask

    // holds the request until an enabled edge takes it
    task automatic send_req(input tcu_pkg::tcu_req_t r, input bit toggle_en);
        bit accepted;
        accepted = 1'b0;
        while (!accepted) begin
            enable    = toggle_en ? (($random(seed) & 3) != 0) : 1'b1;
            req_valid = 1'b1;
            req       = r;
            @(posedge clk);
            accepted = enable;
            #1;
        end
        req_valid = 1'b0;
        // the accepting edge answers a bad format right away
        check_val("fmt_error", fmt_error, !supported_fmt(r.fmt));
        if (supported_fmt(r.fmt)) begin
            exp_q.push_back(model_rsp(r));
            acc_q.push_back(en_edges);
            sent_ok++;
        end else begin
            exp_ferr++;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        enable = 1'b1;
        while (exp_q.size() != 0) begin
            idle(1);
            waited++;
            if (waited > 4 * RSP_LAT) abort_run("expected response never arrived");
        end
        // late or extra responses show up in the quiet window
        idle(QUIET);
        check_val("response count", rsp_count, sent_ok);
        check_val("fmt_error pulses", ferr_count, exp_ferr);
    endtask

    task automatic test_int8_signed();
        tcu_pkg::tcu_req_t r;
        tcu_pkg::tcu_rsp_t m;
        r.fmt       = tcu_pkg::TCU_FMT_I8;
        r.a_row     = {`TCU_N{32'h80808080}};
        r.b_cols[0] = {`TCU_N{32'h80808080}};
        r.b_cols[1] = {`TCU_N{32'h7f7f7f7f}};
        r.b_cols[2] = {`TCU_N{32'hff01ff01}};
        r.b_cols[3] = {32'h01020304, 32'hfefdfcfb, 32'h80000000, 32'h7f7f7f7f};
        r.c_vals    = {32'h80000000, 32'd7, 32'hfffffffb, 32'hfffffc18};
        // sixteen -128 * -128 products minus 1000
        m = model_rsp(r);
        check_val("model int8 lane 0", m.d[0], 32'd261144);
        send_req(r, 1'b0);
        r.a_row = {32'h7f80ff01, 32'h01ff807f, 32'h00000000, 32'h80808080};
        send_req(r, 1'b0);
        drain();
    endtask

    task automatic test_uint8_wrap();
        tcu_pkg::tcu_req_t r;
        tcu_pkg::tcu_rsp_t m;
        r.fmt    = tcu_pkg::TCU_FMT_U8;
        r.a_row  = '1;
        r.b_cols = '1;
        r.c_vals = {32'd0, 32'd1, 32'hfff10000, 32'hffffffff};
        m = model_rsp(r);
        check_val("model uint8 lane 0", m.d[0], 32'h000fe00f);
        check_val("model uint8 lane 1", m.d[1], 32'h0000e010);
        send_req(r, 1'b0);
        drain();
    endtask

    // same data in both nibble formats so sign handling must differ
    task automatic test_int4();
        tcu_pkg::tcu_req_t r;
        for (int i = 0; i < 3; i++) begin
            rand_req(3'd3, r);
            send_req(r, 1'b0);
            r.fmt = tcu_pkg::TCU_FMT_U4;
            send_req(r, 1'b0);
        end
        drain();
    endtask

    task automatic test_stream();
        tcu_pkg::tcu_req_t r;
        for (int i = 0; i < 20; i++) begin
            rand_req(3'(1 + ($unsigned($random(seed)) % 4)), r);
            send_req(r, 1'b1);
        end
        drain();
    endtask

    task automatic test_bad_fmt();
        tcu_pkg::tcu_req_t r;
        logic [2:0]        bad [3];
        bad = '{3'd0, 3'd5, 3'd7};
        for (int i = 0; i < 3; i++) begin
            rand_req(3'd1 + 3'(i), r);
            send_req(r, 1'b0);
            rand_req(bad[i], r);
            send_req(r, 1'b0);
        end
        rand_req(3'd4, r);
        send_req(r, 1'b0);
        drain();
    endtask

    task automatic test_reset_midstream();
        tcu_pkg::tcu_req_t r;
        for (int i = 0; i < 3; i++) begin
            rand_req(3'd2, r);
            send_req(r, 1'b0);
        end
        idle(2);
        // pipeline frozen, so only reset can clear the live slots
        rst_n  = 1'b0;
        enable = 1'b0;
        idle(1);
        // work in flight is flushed by reset
        sent_ok -= exp_q.size();
        exp_q.delete();
        acc_q.delete();
        idle(4);
        rst_n = 1'b1;
        drain();
        rand_req(3'd1, r);
        send_req(r, 1'b0);
        drain();
    endtask

    always @(posedge clk) begin
        edge_en  <= enable;
        edge_rst <= rst_n;
        if (enable && rst_n) en_edges <= en_edges + 1;
    end

    // outputs settle at the rising edge, so they are sampled at the falling edge
    always @(negedge clk) begin : monitor
        tcu_pkg::tcu_rsp_t exp_rsp;
        int                acc_edge;
        if (edge_rst !== 1'b1) begin
            check_val("rsp_valid in reset", rsp_valid, 1'b0);
            check_val("fmt_error in reset", fmt_error, 1'b0);
        end else if (!edge_en) begin
            check_val("rsp_valid hold", rsp_valid, prev_valid);
            check_val("fmt_error hold", fmt_error, prev_ferr);
            for (int l = 0; l < `TCU_LANES; l++) begin
                check_val($sformatf("rsp.d[%0d] hold", l), rsp.d[l], prev_rsp.d[l]);
            end
        end else begin
            if (rsp_valid) begin
                if (exp_q.size() == 0) abort_run("response arrived with no request outstanding");
                exp_rsp  = exp_q.pop_front();
                acc_edge = acc_q.pop_front();
                rsp_count++;
                check_val("latency in enabled cycles", en_edges - acc_edge + 1, RSP_LAT);
                for (int l = 0; l < `TCU_LANES; l++) begin
                    check_val($sformatf("rsp.d[%0d]", l), rsp.d[l], exp_rsp.d[l]);
                end
            end
            if (fmt_error) ferr_count++;
        end
        prev_valid = rsp_valid;
        prev_ferr  = fmt_error;
        prev_rsp   = rsp;
    end

    initial begin : watchdog
        #((NUM_REQS * 20 + 300) * CLK_PERIOD);
        abort_run("watchdog timeout, the tests did not complete in time");
    end

    initial begin
        seed      = 32'h602b;
        rst_n     = 1'b0;
        enable    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n  = 1'b1;
        enable = 1'b1;
        test_int8_signed();
        test_uint8_wrap();
        test_int4();
        test_stream();
        test_bad_fmt();
        test_reset_midstream();
        $display("TEST OK");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+hdl
hdl/tcu_pkg.sv
hdl/tcu_pipe_reg.sv
hdl/tcu_fedp_int.sv
hdl/tcu_operand_dispatch.sv
hdl/tcu_result_collect.sv
hdl/tcu_int_tile.sv
tb/tcu_int_tile_assert.sv
tb/tcu_int_tile_tb.sv
